//--- design/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
    input  logic               CLK,
    input  logic               RST,
    input  logic               stall_i,
    input  isa_pkg::instr_t    instr_i,
    input  fetch_pkg::addr_t   pc_i,
    input  logic [15:0]        reg_data_i,
    fetch_ctrl_if.resolver     ctrl,
    output logic               id_valid_o,
    output isa_pkg::instr_t    id_instr_o,
    output fetch_pkg::addr_t   id_pc_o
);
    import isa_pkg::*;
    import fetch_pkg::*;

    ////////////////////////////////////////
    // Fetch/decode register
    ////////////////////////////////////////

    // Same first-edge rule as the PC unit
    logic    startup;
    logic    id_valid;
    instr_t  id_instr;
    addr_t   id_pc;

    // Decode results
    opcode_e id_op;
    logic    reg_zero;
    logic    jr_hit;
    logic    branch_hit;
    logic    taken;
    logic    redirect;

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            startup  <= 1'b1;
            id_valid <= 1'b0;
        end else if (!stall_i) begin
            if (startup) begin
                startup <= 1'b0;
            end else begin
                // Wrong-path word becomes a bubble
                id_valid <= !redirect;
            end
        end
    end

    // Payload only moves on a real load
    always_ff @(posedge CLK) begin
        if (!stall_i && !startup && !redirect) begin
            id_instr <= instr_i;
            id_pc    <= pc_i;
        end
    end

    ////////////////////////////////////////
    // Branch and JR resolution
    ////////////////////////////////////////

    assign id_op    = opcode_e'(id_instr[INSTR_W-1 -: OPC_W]);
    assign reg_zero = (reg_data_i == '0);

    // Nothing resolves on a bubble
    always_comb begin
        jr_hit     = 1'b0;
        branch_hit = 1'b0;
        taken      = 1'b0;
        if (id_valid) begin
            case (id_op)
                OP_B: begin
                    branch_hit = 1'b1;
                    taken      = 1'b1;
                end
                OP_BEQZ: begin
                    branch_hit = 1'b1;
                    taken      = reg_zero;
                end
                OP_BNEZ: begin
                    branch_hit = 1'b1;
                    taken      = !reg_zero;
                end
                // Rest of the group is other ALU work
                OP_JR_GRP: begin
                    jr_hit = (id_instr[JR_ZERO_W-1:0] == '0);
                end
                default: begin
                    jr_hit = 1'b0;
                end
            endcase
        end
    end

    // Either one means the next fetch is on the wrong path
    assign redirect = jr_hit || taken;

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    assign ctrl.jr         = jr_hit;
    assign ctrl.jr_target  = reg_data_i;
    assign ctrl.is_branch  = branch_hit;
    // Taken is only ever set for a branch
    assign ctrl.mispredict = taken;

    assign id_valid_o = id_valid;
    assign id_instr_o = id_instr;
    assign id_pc_o    = id_pc;

endmodule

//--- design/fetch_ctrl_if.sv
`timescale 1ns/1ps

// Redirect control from the decode stage to the PC unit
interface fetch_ctrl_if;
    import fetch_pkg::*;

    // JR sitting in decode
    logic  jr;

    // JR destination, taken straight from the register operand
    addr_t jr_target;

    // Any B, BEQZ or BNEZ in decode
    logic  is_branch;

    // Branch in decode resolved as taken
    // Static not-taken prediction, so taken means wrong path fetched
    logic  mispredict;

    // Decode side
    modport resolver (
        output jr,
        output jr_target,
        output is_branch,
        output mispredict
    );

    // PC side
    modport pcunit (
        input jr,
        input jr_target,
        input is_branch,
        input mispredict
    );

endinterface

//--- design/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////
    // Addressing
    ////////////////////////////////////////

    // Word address width
    localparam int ADDR_W = 16;

    typedef logic [ADDR_W-1:0] addr_t;

    // First fetch address after reset
    localparam addr_t RESET_PC = '0;

    ////////////////////////////////////////
    // Program ROM
    ////////////////////////////////////////

    // Words held in the ROM
    localparam int ROM_DEPTH = 256;

    // Address bits used for the ROM lookup
    localparam int ROM_AW = $clog2(ROM_DEPTH);

    // Hex image loaded at elaboration
    localparam string ROM_FILE = "program.hex";

endpackage

//--- design/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
    input  logic              CLK,
    input  logic              RST,
    input  logic              stall_i,
    input  logic [15:0]       reg_data_i,
    output fetch_pkg::addr_t  pc_o,
    output fetch_pkg::addr_t  epc_o,
    output logic              id_valid_o,
    output isa_pkg::instr_t   id_instr_o,
    output fetch_pkg::addr_t  id_pc_o
);
    import isa_pkg::*;

    ////////////////////////////////////////
    // Interconnect
    ////////////////////////////////////////

    // Word read at the current fetch PC
    instr_t fetch_instr;

    // Redirect path from decode back to the PC
    fetch_ctrl_if ctrl_if ();

    ////////////////////////////////////////
    // Fetch stage
    ////////////////////////////////////////

    // ROM addressed directly by the PC
    instr_rom u_rom (
        .addr_i  (pc_o),
        .instr_o (fetch_instr)
    );

    // PC and next-PC selection
    ifetch u_ifetch (
        .CLK     (CLK),
        .RST     (RST),
        .stall_i (stall_i),
        .instr_i (fetch_instr),
        .ctrl    (ctrl_if.pcunit),
        .pc_o    (pc_o),
        .epc_o   (epc_o)
    );

    ////////////////////////////////////////
    // Decode stage
    ////////////////////////////////////////

    // Pipeline register plus branch resolution
    branch_resolve u_decode (
        .CLK        (CLK),
        .RST        (RST),
        .stall_i    (stall_i),
        .instr_i    (fetch_instr),
        .pc_i       (pc_o),
        .reg_data_i (reg_data_i),
        .ctrl       (ctrl_if.resolver),
        .id_valid_o (id_valid_o),
        .id_instr_o (id_instr_o),
        .id_pc_o    (id_pc_o)
    );

endmodule

//--- design/ifetch.sv
`timescale 1ns/1ps

module ifetch (
    input  logic                CLK,
    input  logic                RST,
    input  logic                stall_i,
    input  isa_pkg::instr_t     instr_i,
    fetch_ctrl_if.pcunit        ctrl,
    output fetch_pkg::addr_t    pc_o,
    output fetch_pkg::addr_t    epc_o
);
    import isa_pkg::*;
    import fetch_pkg::*;

    ////////////////////////////////////////
    // State
    ////////////////////////////////////////

    // Set by reset, cleared by the first unstalled edge
    logic    startup;

    // Fetch PC
    addr_t   pc;

    // Address of the word now in decode
    addr_t   pc_lock;

    // Target of the word now in decode, if it is a branch
    addr_t   target_lock;

    // Combinational next-PC path
    opcode_e fetch_op;
    addr_t   ext_imm;
    addr_t   pc_plus1;
    addr_t   pc_plus_imm;
    addr_t   next_pc;

    ////////////////////////////////////////
    // Target precompute
    ////////////////////////////////////////

    // Opcode of the word coming out of the ROM
    assign fetch_op = opcode_e'(instr_i[INSTR_W-1 -: OPC_W]);

    // Sign extension
    // OP_B carries the long offset, everything else the short one
    always_comb begin
        if (fetch_op == OP_B) begin
            ext_imm = {{(ADDR_W-IMM_LONG_W){instr_i[IMM_LONG_W-1]}},
                       instr_i[IMM_LONG_W-1:0]};
        end else begin
            ext_imm = {{(ADDR_W-IMM_SHORT_W){instr_i[IMM_SHORT_W-1]}},
                       instr_i[IMM_SHORT_W-1:0]};
        end
    end

    assign pc_plus1    = pc + addr_t'(1);
    // Offsets are relative to the following word
    assign pc_plus_imm = pc_plus1 + ext_imm;

    // JR wins over a taken branch, sequential otherwise
    assign next_pc = ctrl.jr         ? ctrl.jr_target :
                     ctrl.mispredict ? target_lock    :
                                       pc_plus1;

    ////////////////////////////////////////
    // PC register
    ////////////////////////////////////////

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            pc      <= RESET_PC;
            startup <= 1'b1;
        end else if (!stall_i) begin
            // Startup edge only drops the flag
            if (startup) begin
                startup <= 1'b0;
            end else begin
                pc <= next_pc;
            end
        end
    end

    // Follows the word into decode
    always_ff @(posedge CLK) begin
        if (!stall_i && !startup) begin
            pc_lock     <= pc;
            target_lock <= pc_plus_imm;
        end
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    assign pc_o  = pc;

    // Restart at the control transfer while one sits in decode
    assign epc_o = (ctrl.is_branch || ctrl.jr) ? pc_lock : pc;

endmodule

//--- design/instr_rom.sv
`timescale 1ns/1ps

module instr_rom (
    input  fetch_pkg::addr_t addr_i,
    output isa_pkg::instr_t  instr_o
);
    import isa_pkg::*;
    import fetch_pkg::*;

    // Program storage
    instr_t rom [ROM_DEPTH];

    // Preset with NOPs, then overlay the image
    // Words past the end of the image stay NOP
    initial begin
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = {OP_NOP, {(INSTR_W-OPC_W){1'b0}}};
        end
        $readmemh(ROM_FILE, rom);
    end

    // Asynchronous read
    // Upper address bits wrap onto the ROM
    assign instr_o = rom[addr_i[ROM_AW-1:0]];

endmodule

//--- design/isa_pkg.sv
package isa_pkg;

    ////////////////////////////////////////
    // Instruction word
    ////////////////////////////////////////

    // Fixed 16-bit encoding
    localparam int INSTR_W = 16;

    // Opcode sits in the top bits
    localparam int OPC_W = 5;

    typedef logic [INSTR_W-1:0] instr_t;

    ////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////

    // Only the opcodes the front end cares about
    typedef enum logic [OPC_W-1:0] {
        // Filler word for unloaded ROM locations
        OP_NOP    = 5'b00001,
        // Unconditional branch with long immediate
        OP_B      = 5'b00010,
        // Branch if register operand is zero
        OP_BEQZ   = 5'b00100,
        // Branch if register operand is nonzero
        OP_BNEZ   = 5'b00101,
        // Group holding JR
        OP_JR_GRP = 5'b11101
    } opcode_e;

    ////////////////////////////////////////
    // Immediate fields
    ////////////////////////////////////////

    // Branch offset of OP_B
    localparam int IMM_LONG_W = 11;

    // Branch offset of the conditional branches
    localparam int IMM_SHORT_W = 8;

    // JR only when these low bits are all zero
    localparam int JR_ZERO_W = 8;

endpackage

//--- frontend.f
design/isa_pkg.sv
design/fetch_pkg.sv
design/fetch_ctrl_if.sv
design/ifetch.sv
design/instr_rom.sv
design/branch_resolve.sv
design/frontend_top.sv
verif/frontend_sva.sv
verif/frontend_tb.sv

//--- program.hex
// One 16-bit instruction word per line, hex, starting at address 0
// Opcode in bits 15:11, branch offset in the low 11 or 8 bits
0800
1801
3002
2002
4004
2803
1802
E801
20FC
1003
4444
0800
3333
28FA
E800
17F0
1801

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module frontend_tb -f frontend.f \
    -o frontend_sim > build.log 2>&1 \
    && ./obj_dir/frontend_sim 2>&1 | tee sim.log \
    || echo "build or simulation exited with an error, see build.log"
grep -qx "TESTBENCH PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

//--- verif/frontend_sva.sv
`timescale 1ns/1ps

module frontend_sva (
    input logic             CLK,
    input logic             RST,
    input logic             stall_i,
    input logic             redirect_i,
    input logic             id_valid_i,
    input isa_pkg::instr_t  id_instr_i,
    input fetch_pkg::addr_t id_pc_i
);
    import isa_pkg::*;
    import fetch_pkg::*;

    // Decode only empties on a redirect edge
    // Not-taken branches and plain words keep it full
    only_redirect_empties: assert property (
        @(posedge CLK) disable iff (!RST)
        (id_valid_i && !redirect_i && !stall_i) |=> id_valid_i
    ) else $error("decode emptied without a redirect");

    // Stalled edge leaves the decode register alone
    stall_holds_valid: assert property (
        @(posedge CLK) disable iff (!RST) stall_i |=> $stable(id_valid_i)
    ) else $error("decode valid changed under stall");

    // Payload too, once something has been loaded
    stall_holds_payload: assert property (
        @(posedge CLK) disable iff (!RST)
        (stall_i && id_valid_i) |=> ($stable(id_instr_i) && $stable(id_pc_i))
    ) else $error("decode payload changed under stall");

    // Wrong-path word must come in as a bubble
    redirect_flushes: assert property (
        @(posedge CLK) disable iff (!RST) (redirect_i && !stall_i) |=> !id_valid_i
    ) else $error("decode valid after a redirect edge");

endmodule

bind branch_resolve frontend_sva u_sva (
    .CLK        (CLK),
    .RST        (RST),
    .stall_i    (stall_i),
    .redirect_i (redirect),
    .id_valid_i (id_valid),
    .id_instr_i (id_instr),
    .id_pc_i    (id_pc)
);

//--- verif/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb;
    import isa_pkg::*;
    import fetch_pkg::*;

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    typedef struct packed {
        logic        stall;
        logic [15:0] rdata;
        addr_t       pc;
    } step_t;

    localparam int N_STEPS  = 40;
    localparam int N_RANDOM = 200;
    localparam int WAIT_MAX = 8;

    // Stall, register operand, fetch PC expected during that cycle
    localparam step_t STEPS [N_STEPS] = '{
        // Straight line, BEQZ at 3 not taken
        '{1'b0, 16'h0, 16'h1}, '{1'b0, 16'h0, 16'h2}, '{1'b0, 16'h0, 16'h3},
        '{1'b0, 16'h5, 16'h4}, '{1'b0, 16'h0, 16'h5},
        // BNEZ at 5 taken, stalled twice in decode
        '{1'b1, 16'h7, 16'h6}, '{1'b1, 16'h7, 16'h6}, '{1'b0, 16'h7, 16'h6},
        // B at 9, BNEZ at D not taken
        '{1'b0, 16'h0, 16'h9}, '{1'b0, 16'h0, 16'hA}, '{1'b0, 16'h0, 16'hD},
        '{1'b0, 16'h0, 16'hE},
        // JR held by a stall, target 3
        '{1'b1, 16'h3, 16'hF}, '{1'b1, 16'h3, 16'hF}, '{1'b0, 16'h3, 16'hF},
        // BEQZ taken, then BEQZ back by 4
        '{1'b0, 16'h0, 16'h3}, '{1'b0, 16'h0, 16'h4}, '{1'b0, 16'h0, 16'h6},
        '{1'b0, 16'h0, 16'h7}, '{1'b0, 16'h0, 16'h8}, '{1'b0, 16'h0, 16'h9},
        // Stall over the bubble, BNEZ not taken
        '{1'b1, 16'h0, 16'h5}, '{1'b0, 16'h0, 16'h5}, '{1'b0, 16'h0, 16'h6},
        '{1'b0, 16'h0, 16'h7}, '{1'b0, 16'h0, 16'h8},
        // BEQZ not taken, B held by a stall
        '{1'b0, 16'h1, 16'h9}, '{1'b1, 16'h1, 16'hA}, '{1'b0, 16'h1, 16'hA},
        // BNEZ back by 6, BEQZ not taken, B again
        '{1'b0, 16'h0, 16'hD}, '{1'b0, 16'h2, 16'hE}, '{1'b0, 16'h0, 16'h8},
        '{1'b0, 16'h4, 16'h9}, '{1'b0, 16'h0, 16'hA}, '{1'b0, 16'h0, 16'hD},
        // JR to F, long backward B to 0
        '{1'b0, 16'h0, 16'hE}, '{1'b0, 16'hF, 16'hF}, '{1'b0, 16'h0, 16'hF},
        '{1'b0, 16'h0, 16'h10}, '{1'b0, 16'h0, 16'h0}
    };

    logic        CLK;
    logic        RST;
    logic        stall_i;
    logic [15:0] reg_data_i;
    addr_t       pc_o;
    addr_t       epc_o;
    logic        id_valid_o;
    instr_t      id_instr_o;
    addr_t       id_pc_o;

    // Reference model state
    instr_t      prog [ROM_DEPTH];
    logic        m_startup;
    logic        m_valid;
    instr_t      m_instr;
    addr_t       m_pc;
    addr_t       m_id_pc;
    addr_t       m_target;
    int          checks;
    int          errors;
    logic [31:0] rnd;

    frontend_top uut (
        .CLK        (CLK),
        .RST        (RST),
        .stall_i    (stall_i),
        .reg_data_i (reg_data_i),
        .pc_o       (pc_o),
        .epc_o      (epc_o),
        .id_valid_o (id_valid_o),
        .id_instr_o (id_instr_o),
        .id_pc_o    (id_pc_o)
    );

    always #2 CLK = ~CLK;

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%04h, expected 0x%04h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_instr(input string name, input instr_t got, input instr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%04h, expected 0x%04h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // What the model's decode word does with this operand
    task automatic resolve(input logic [15:0] rdata, output logic jr, output logic br,
                           output logic taken);
        logic [4:0] op;
        op    = m_instr[15:11];
        br    = m_valid && (op == OP_B || op == OP_BEQZ || op == OP_BNEZ);
        jr    = m_valid && op == OP_JR_GRP && m_instr[7:0] == 8'h00;
        taken = m_valid && (op == OP_B || (op == OP_BEQZ && rdata == 16'h0)
                            || (op == OP_BNEZ && rdata != 16'h0));
    endtask

    // One clock edge of the front end
    task automatic model_step(input logic stall, input logic [15:0] rdata);
        logic   jr;
        logic   br;
        logic   taken;
        instr_t w;
        addr_t  ext;
        addr_t  nxt;
        if (!stall && m_startup) begin
            m_startup = 1'b0;
        end else if (!stall) begin
            resolve(rdata, jr, br, taken);
            w = prog[m_pc[7:0]];
            // Long offset only on B
            if (w[15:11] == OP_B) begin
                ext = addr_t'($signed(w[10:0]));
            end else begin
                ext = addr_t'($signed(w[7:0]));
            end
            if (!(jr || taken)) begin
                m_instr = w;
                m_id_pc = m_pc;
            end
            m_valid  = !(jr || taken);
            nxt      = jr ? rdata : (taken ? m_target : m_pc + 16'd1);
            m_target = m_pc + 16'd1 + ext;
            m_pc     = nxt;
        end
    endtask

    task automatic compare_outputs(input logic [15:0] rdata);
        logic jr;
        logic br;
        logic taken;
        resolve(rdata, jr, br, taken);
        check_addr("pc_o", pc_o, m_pc);
        check_bit("id_valid_o", id_valid_o, m_valid);
        // Payload is don't-care on a bubble
        if (m_valid) begin
            check_instr("id_instr_o", id_instr_o, m_instr);
            check_addr("id_pc_o", id_pc_o, m_id_pc);
        end
        check_addr("epc_o", epc_o, (br || jr) ? m_id_pc : m_pc);
    endtask

    // Drive, check mid-cycle, then step the model on the edge
    task automatic run_cycle(input logic stall, input logic [15:0] rdata);
        stall_i    = stall;
        reg_data_i = rdata;
        @(negedge CLK);
        compare_outputs(rdata);
        @(posedge CLK);
        model_step(stall, rdata);
        #0.5;
    endtask

    task automatic report_test(input string name, input int c0, input int e0);
        $display("%-16s %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        int c0;
        int e0;
        int edges;
        CLK        = 1'b0;
        RST        = 1'b0;
        stall_i    = 1'b0;
        reg_data_i = 16'h0;
        checks     = 0;
        errors     = 0;
        rnd        = 32'h56bf8b0c;
        for (int i = 0; i < ROM_DEPTH; i++) begin
            prog[i] = {OP_NOP, 11'h000};
        end
        $readmemh(ROM_FILE, prog);
        m_startup = 1'b1;
        m_valid   = 1'b0;
        m_instr   = '0;
        m_pc      = RESET_PC;
        m_id_pc   = '0;
        m_target  = '0;

        repeat (4) @(posedge CLK);
        #0.5;
        RST = 1'b1;
        c0  = checks;
        e0  = errors;
        check_addr("pc_o", pc_o, RESET_PC);
        check_bit("id_valid_o", id_valid_o, 1'b0);
        // First word should land in decode on the second edge
        edges = 0;
        while (id_valid_o !== 1'b1 && edges < WAIT_MAX) begin
            run_cycle(1'b0, 16'h0);
            edges++;
        end
        if (id_valid_o !== 1'b1) begin
            $display("Timeout: decode never became valid after reset");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            if (edges != 2) begin
                errors++;
                $display("Startup took %0d unstalled edges instead of 2", edges);
            end
            report_test("reset/startup", c0, e0);

            c0 = checks;
            e0 = errors;
            for (int i = 0; i < N_STEPS; i++) begin
                check_addr("pc_o", pc_o, STEPS[i].pc);
                run_cycle(STEPS[i].stall, STEPS[i].rdata);
            end
            report_test("directed table", c0, e0);

            // Operand kept small so JR lands inside the image
            c0 = checks;
            e0 = errors;
            for (int i = 0; i < N_RANDOM; i++) begin
                rnd = xorshift(rnd);
                run_cycle(rnd[1:0] == 2'b00, rnd[4] ? 16'h0 : {12'h000, rnd[11:8]});
            end
            report_test("random", c0, e0);

            $display("Total: %0d checks, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

endmodule
